/* flist.f */
+incdir+include
src/axis_pkg.sv
src/axis_frame_fifo.sv
src/axis_rr_arbiter.sv
src/frame_status_counters.sv
src/axis_aggregator_top.sv
tests/axis_aggregator_props.sv
tests/tb_axis_aggregator.sv

/* include/axis_params.svh */
`ifndef AXIS_PARAMS_SVH
`define AXIS_PARAMS_SVH

////////////////////////////////////////////////////////////////////////////
// stream widths
////////////////////////////////////////////////////////////////////////////

`define AXIS_DATA_W 8           // data bits per beat.

////////////////////////////////////////////////////////////////////////////
// FIFO and aggregator sizing
////////////////////////////////////////////////////////////////////////////

`define AXIS_FIFO_ADDR_W 4      // 16 entries per port.

`define AXIS_NUM_PORTS 2        // input ports into the arbiter.

////////////////////////////////////////////////////////////////////////////
// statistics
////////////////////////////////////////////////////////////////////////////

`define AXIS_CNT_W 16           // saturating frame counters.

`endif

/* run.sh */
#!/bin/sh
# Build and run the aggregator testbench with Verilator.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
  --top-module tb_axis_aggregator -f flist.f -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q -F '*** PASSED ***' sim.log; then
  echo "simulation passed"
else
  echo "simulation did not pass"
  exit 1
fi

/* src/axis_aggregator_top.sv */
`default_nettype none

`include "axis_params.svh"

module axis_aggregator_top (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     s_valid        [`AXIS_NUM_PORTS],
  output logic                     s_ready        [`AXIS_NUM_PORTS],
  input  axis_pkg::axis_beat_t     s_beat         [`AXIS_NUM_PORTS],
  output logic                     out_valid,
  input  logic                     out_ready,
  output axis_pkg::axis_out_beat_t out_beat,
  output logic [`AXIS_CNT_W-1:0]   good_count     [`AXIS_NUM_PORTS],
  output logic [`AXIS_CNT_W-1:0]   bad_count      [`AXIS_NUM_PORTS],
  output logic [`AXIS_CNT_W-1:0]   overflow_count [`AXIS_NUM_PORTS]
);
  import axis_pkg::*;

  logic          fifo_valid  [`AXIS_NUM_PORTS];
  logic          fifo_ready  [`AXIS_NUM_PORTS];
  axis_beat_t    fifo_beat   [`AXIS_NUM_PORTS];
  frame_status_t fifo_status [`AXIS_NUM_PORTS];

  ////////////////////////////////////////////////////////////////////////////
  // per port frame FIFOs
  ////////////////////////////////////////////////////////////////////////////

  for (genvar p = 0; p < `AXIS_NUM_PORTS; p++) begin : g_port
    axis_frame_fifo fifo_i (
      .clk     (clk),
      .rst     (rst),
      .s_valid (s_valid[p]),
      .s_ready (s_ready[p]),
      .s_beat  (s_beat[p]),
      .m_valid (fifo_valid[p]),
      .m_ready (fifo_ready[p]),
      .m_beat  (fifo_beat[p]),
      .status  (fifo_status[p])
    );
  end

  ////////////////////////////////////////////////////////////////////////////
  // merge and statistics
  ////////////////////////////////////////////////////////////////////////////

  axis_rr_arbiter arb_i (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (fifo_valid),
    .in_ready  (fifo_ready),
    .in_beat   (fifo_beat),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_beat  (out_beat)
  );

  frame_status_counters cnt_i (
    .clk            (clk),
    .rst            (rst),
    .status         (fifo_status),
    .good_count     (good_count),
    .bad_count      (bad_count),
    .overflow_count (overflow_count)
  );

endmodule

`default_nettype wire

/* src/axis_frame_fifo.sv */
`default_nettype none

`include "axis_params.svh"

module axis_frame_fifo (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    s_valid,
  output logic                    s_ready,
  input  axis_pkg::axis_beat_t    s_beat,
  output logic                    m_valid,
  input  logic                    m_ready,
  output axis_pkg::axis_beat_t    m_beat,
  output axis_pkg::frame_status_t status
);
  import axis_pkg::*;

  localparam int ADDR_W = `AXIS_FIFO_ADDR_W;
  localparam int DEPTH  = 2 ** ADDR_W;

  axis_beat_t      mem [DEPTH];

  logic [ADDR_W:0] wr_ptr;            // committed frames end here.
  logic [ADDR_W:0] wr_ptr_next;
  logic [ADDR_W:0] wr_ptr_cur;        // frame in progress.
  logic [ADDR_W:0] wr_ptr_cur_next;
  logic [ADDR_W:0] rd_ptr;            // next entry to fetch.
  logic [ADDR_W:0] rel_ptr;           // entries handed out on the m side.
  logic [ADDR_W:0] used_cur;

  logic            accept;
  logic            write;
  logic            full_cur;
  logic            empty;
  logic            drop_frame;
  logic            drop_frame_next;
  frame_status_t   status_next;

  axis_beat_t      mem_rd_data;
  logic            mem_rd_valid;
  logic            load_mem;
  logic            fetch;
  logic            store_output;

  ////////////////////////////////////////////////////////////////////////////
  // write side
  ////////////////////////////////////////////////////////////////////////////

  assign s_ready = 1'b1;              // frames are dropped, never stalled.
  assign accept  = s_valid && s_ready;

  // space is only given back once a beat has left on the m side.
  assign used_cur = wr_ptr_cur - rel_ptr;
  assign full_cur = used_cur[ADDR_W];

  always_comb begin
    write           = 1'b0;
    wr_ptr_next     = wr_ptr;
    wr_ptr_cur_next = wr_ptr_cur;
    drop_frame_next = drop_frame;
    status_next     = '0;
    if (accept) begin
      if (full_cur || drop_frame) begin
        drop_frame_next = 1'b1;       // swallow the rest of the frame.
        if (s_beat.last) begin
          drop_frame_next      = 1'b0;
          wr_ptr_cur_next      = wr_ptr;
          status_next.overflow = 1'b1;
        end
      end else begin
        write           = 1'b1;
        wr_ptr_cur_next = wr_ptr_cur + 1'b1;
        if (s_beat.last) begin
          if (s_beat.bad) begin
            wr_ptr_cur_next = wr_ptr; // rewind.
            status_next.bad = 1'b1;
          end else begin
            wr_ptr_next      = wr_ptr_cur + 1'b1;
            status_next.good = 1'b1;
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr     <= '0;
      wr_ptr_cur <= '0;
      drop_frame <= 1'b0;
      status     <= '0;
    end else begin
      wr_ptr     <= wr_ptr_next;
      wr_ptr_cur <= wr_ptr_cur_next;
      drop_frame <= drop_frame_next;
      status     <= status_next;
    end
  end

  always_ff @(posedge clk) begin
    if (write) begin
      mem[wr_ptr_cur[ADDR_W-1:0]] <= s_beat;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // read side
  ////////////////////////////////////////////////////////////////////////////

  assign empty        = (rd_ptr == wr_ptr); // committed space only.
  assign store_output = m_ready || !m_valid;
  assign load_mem     = store_output || !mem_rd_valid;
  assign fetch        = load_mem && !empty;

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_ptr       <= '0;
      rel_ptr      <= '0;
      mem_rd_valid <= 1'b0;
      m_valid      <= 1'b0;
    end else begin
      if (fetch) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (load_mem) begin
        mem_rd_valid <= !empty;
      end
      if (store_output) begin
        m_valid <= mem_rd_valid;
      end
      if (m_valid && m_ready) begin
        rel_ptr <= rel_ptr + 1'b1;    // entry is free again.
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fetch) begin
      mem_rd_data <= mem[rd_ptr[ADDR_W-1:0]];
    end
    if (store_output) begin
      m_beat <= mem_rd_data;          // held while stalled.
    end
  end

endmodule

`default_nettype wire

/* src/axis_pkg.sv */
`default_nettype none

`include "axis_params.svh"

package axis_pkg;

  // port id width, never below one bit.
  localparam int AXIS_PORT_W = (`AXIS_NUM_PORTS > 1) ? $clog2(`AXIS_NUM_PORTS) : 1;

  // one beat on an input port and inside a FIFO.
  typedef struct packed {
    logic [`AXIS_DATA_W-1:0] data;
    logic                    last;   // end of frame.
    logic                    bad;    // frame error, looked at on last only.
  } axis_beat_t;

  // beat on the shared output, tagged with its source.
  typedef struct packed {
    logic [AXIS_PORT_W-1:0] port;
    axis_beat_t             beat;
  } axis_out_beat_t;

  // single cycle pulses per finished frame.
  typedef struct packed {
    logic good;
    logic bad;
    logic overflow;
  } frame_status_t;

endpackage

`default_nettype wire

/* src/axis_rr_arbiter.sv */
`default_nettype none

`include "axis_params.svh"

module axis_rr_arbiter (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     in_valid [`AXIS_NUM_PORTS],
  output logic                     in_ready [`AXIS_NUM_PORTS],
  input  axis_pkg::axis_beat_t     in_beat  [`AXIS_NUM_PORTS],
  output logic                     out_valid,
  input  logic                     out_ready,
  output axis_pkg::axis_out_beat_t out_beat
);
  import axis_pkg::*;

  localparam int NUM_PORTS = `AXIS_NUM_PORTS;

  logic                   granted;
  logic [AXIS_PORT_W-1:0] grant_port;
  logic [AXIS_PORT_W-1:0] last_port;  // most recently served.
  logic                   pick_found;
  logic [AXIS_PORT_W-1:0] pick_port;
  logic                   frame_done;

  ////////////////////////////////////////////////////////////////////////////
  // round robin pick
  ////////////////////////////////////////////////////////////////////////////

  // search starts one past the last served port and ends on it.
  always_comb begin
    int unsigned idx;
    pick_found = 1'b0;
    pick_port  = last_port;
    for (int i = 1; i <= NUM_PORTS; i++) begin
      idx = (int'(last_port) + i) % NUM_PORTS;
      if (!pick_found && in_valid[idx]) begin
        pick_found = 1'b1;
        pick_port  = AXIS_PORT_W'(idx);
      end
    end
  end

  assign frame_done = out_valid && out_ready && out_beat.beat.last;

  always_ff @(posedge clk) begin
    if (rst) begin
      granted    <= 1'b0;
      grant_port <= '0;
      last_port  <= AXIS_PORT_W'(NUM_PORTS - 1); // port 0 goes first.
    end else if (!granted) begin
      if (pick_found) begin
        granted    <= 1'b1;
        grant_port <= pick_port;
      end
    end else if (frame_done) begin
      granted   <= 1'b0;              // whole frame sent.
      last_port <= grant_port;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // output mux
  ////////////////////////////////////////////////////////////////////////////

  assign out_valid     = granted && in_valid[grant_port];
  assign out_beat.port = grant_port;
  assign out_beat.beat = in_beat[grant_port];

  always_comb begin
    for (int i = 0; i < NUM_PORTS; i++) begin
      in_ready[i] = granted && (grant_port == AXIS_PORT_W'(i)) && out_ready;
    end
  end

endmodule

`default_nettype wire

/* src/frame_status_counters.sv */
`default_nettype none

`include "axis_params.svh"

module frame_status_counters (
  input  logic                    clk,
  input  logic                    rst,
  input  axis_pkg::frame_status_t status         [`AXIS_NUM_PORTS],
  output logic [`AXIS_CNT_W-1:0]  good_count     [`AXIS_NUM_PORTS],
  output logic [`AXIS_CNT_W-1:0]  bad_count      [`AXIS_NUM_PORTS],
  output logic [`AXIS_CNT_W-1:0]  overflow_count [`AXIS_NUM_PORTS]
);

  localparam int NUM_PORTS = `AXIS_NUM_PORTS;
  localparam int CNT_W     = `AXIS_CNT_W;

  // sticks at all ones.
  function automatic logic [CNT_W-1:0] sat_inc(input logic [CNT_W-1:0] cnt,
                                               input logic             en);
    if (en && (cnt != '1)) begin
      return cnt + 1'b1;
    end
    return cnt;
  endfunction

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int p = 0; p < NUM_PORTS; p++) begin
        good_count[p]     <= '0;
        bad_count[p]      <= '0;
        overflow_count[p] <= '0;
      end
    end else begin
      for (int p = 0; p < NUM_PORTS; p++) begin
        good_count[p]     <= sat_inc(good_count[p], status[p].good);
        bad_count[p]      <= sat_inc(bad_count[p], status[p].bad);
        overflow_count[p] <= sat_inc(overflow_count[p], status[p].overflow);
      end
    end
  end

endmodule

`default_nettype wire

/* tests/axis_aggregator_props.sv */
`default_nettype none

`include "axis_params.svh"

module axis_aggregator_props (
  input logic                     clk,
  input logic                     rst,
  input logic                     s_ready        [`AXIS_NUM_PORTS],
  input logic                     out_valid,
  input logic                     out_ready,
  input axis_pkg::axis_out_beat_t out_beat,
  input logic [`AXIS_CNT_W-1:0]   good_count     [`AXIS_NUM_PORTS],
  input logic [`AXIS_CNT_W-1:0]   bad_count      [`AXIS_NUM_PORTS],
  input logic [`AXIS_CNT_W-1:0]   overflow_count [`AXIS_NUM_PORTS]
);
  import axis_pkg::*;

  logic                   xfer;
  logic                   in_frame;     // frame partly sent.
  logic [AXIS_PORT_W-1:0] frame_port;
  logic                   idle_state;
  int unsigned            fail_count = 0; // assertion failures so far.

  assign xfer = out_valid && out_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      in_frame   <= 1'b0;
      frame_port <= '0;
    end else if (xfer) begin
      in_frame   <= !out_beat.beat.last;
      frame_port <= out_beat.port;
    end
  end

  // output idle, counters cleared, inputs open.
  always_comb begin
    idle_state = !out_valid;
    for (int p = 0; p < `AXIS_NUM_PORTS; p++) begin
      if (!s_ready[p] || (good_count[p] != '0) || (bad_count[p] != '0) ||
          (overflow_count[p] != '0)) begin
        idle_state = 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // protocol checks
  ////////////////////////////////////////////////////////////////////////////

  frame_port_held: assert property (@(posedge clk) disable iff (rst)
    (xfer && in_frame) |-> (out_beat.port == frame_port))
    else begin
      $error("output port changed in the middle of a frame");
      fail_count++;
    end

  stall_stable: assert property (@(posedge clk) disable iff (rst)
    (out_valid && !out_ready) |=> (out_valid && $stable(out_beat)))
    else begin
      $error("output beat dropped or changed while stalled");
      fail_count++;
    end

  reset_idle: assert property (@(posedge clk)
    $fell(rst) |-> idle_state)
    else begin
      $error("outputs not in their reset state after reset");
      fail_count++;
    end

endmodule

bind axis_aggregator_top axis_aggregator_props props_i (
  .clk            (clk),
  .rst            (rst),
  .s_ready        (s_ready),
  .out_valid      (out_valid),
  .out_ready      (out_ready),
  .out_beat       (out_beat),
  .good_count     (good_count),
  .bad_count      (bad_count),
  .overflow_count (overflow_count)
);

`default_nettype wire

/* tests/tb_axis_aggregator.sv */
`default_nettype none

`include "axis_params.svh"

module tb_axis_aggregator;
  import axis_pkg::*;

  localparam int NUM_PORTS     = `AXIS_NUM_PORTS;
  localparam int DATA_W        = `AXIS_DATA_W;
  localparam int CNT_W         = `AXIS_CNT_W;
  localparam int DEPTH         = 2 ** `AXIS_FIFO_ADDR_W;
  localparam int CLK_PERIOD    = 4;
  localparam int RESET_CYCLES  = 16;
  localparam int NUM_FRAMES    = 60;     // per port.
  localparam int STALL_EVERY   = 400;
  localparam int STALL_CYCLES  = 80;     // long enough to fill both FIFOs.
  localparam int DRAIN_CYCLES  = 600;
  localparam int WATCHDOG_TIME = (NUM_PORTS * NUM_FRAMES * 40 + 2000) * CLK_PERIOD;
  localparam int unsigned SEED = 32'hba04;

  typedef struct packed {
    logic [31:0] good;
    logic [31:0] bad;
    logic [31:0] overflow;
  } tally_t;

  logic           clk = 1'b0;
  logic           rst;
  logic           s_valid        [NUM_PORTS];
  logic           s_ready        [NUM_PORTS];
  axis_beat_t     s_beat         [NUM_PORTS];
  logic           out_valid;
  logic           out_ready;
  axis_out_beat_t out_beat;
  logic [CNT_W-1:0] good_count     [NUM_PORTS];
  logic [CNT_W-1:0] bad_count      [NUM_PORTS];
  logic [CNT_W-1:0] overflow_count [NUM_PORTS];

  // reference model state.
  axis_beat_t ref_q    [NUM_PORTS][$];
  axis_beat_t pend_q   [NUM_PORTS][$];
  int         committed [NUM_PORTS];   // committed, not yet sent out.
  int         cur_len   [NUM_PORTS];
  bit         dropping  [NUM_PORTS];
  tally_t     tally     [NUM_PORTS];
  tally_t     tally_d1  [NUM_PORTS];
  tally_t     tally_d2  [NUM_PORTS];

  axis_aggregator_top dut_i (
    .clk            (clk),
    .rst            (rst),
    .s_valid        (s_valid),
    .s_ready        (s_ready),
    .s_beat         (s_beat),
    .out_valid      (out_valid),
    .out_ready      (out_ready),
    .out_beat       (out_beat),
    .good_count     (good_count),
    .bad_count      (bad_count),
    .overflow_count (overflow_count)
  );

  initial begin
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // error reporting
  ////////////////////////////////////////////////////////////////////////////

  task automatic stop_run();
    $display("*** FAILED ***");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic report_error(input string why);
    $display("%s", why);
    stop_run();
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] got);
    $display("FAILED %s: expected 0x%0h, got 0x%0h", name, exp, got);
    stop_run();
  endtask

  function automatic int beats_outstanding();
    int total;
    total = 0;
    for (int p = 0; p < NUM_PORTS; p++) begin
      total += ref_q[p].size();
    end
    return total;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // reference model and checks
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin : model
    axis_beat_t beat;
    axis_beat_t exp_beat;
    int         port;
    int         released [NUM_PORTS];
    if (rst) begin
      for (int p = 0; p < NUM_PORTS; p++) begin
        committed[p] = 0;
        cur_len[p]   = 0;
        dropping[p]  = 1'b0;
        tally[p]     = '0;
        tally_d1[p]  = '0;
        tally_d2[p]  = '0;
        ref_q[p].delete();
        pend_q[p].delete();
      end
    end else begin
      assert (dut_i.props_i.fail_count == 0)
        else report_error("a protocol assertion on the output stream failed");
      // counters lag the frame end by two cycles.
      for (int p = 0; p < NUM_PORTS; p++) begin
        assert (good_count[p] == CNT_W'(tally_d2[p].good))
          else report_mismatch($sformatf("good_count[%0d]", p), tally_d2[p].good,
                               32'(good_count[p]));
        assert (bad_count[p] == CNT_W'(tally_d2[p].bad))
          else report_mismatch($sformatf("bad_count[%0d]", p), tally_d2[p].bad,
                               32'(bad_count[p]));
        assert (overflow_count[p] == CNT_W'(tally_d2[p].overflow))
          else report_mismatch($sformatf("overflow_count[%0d]", p),
                               tally_d2[p].overflow, 32'(overflow_count[p]));
        released[p] = 0;
      end
      if (out_valid && out_ready) begin
        port = int'(out_beat.port);
        assert (ref_q[port].size() > 0)
          else report_error($sformatf("port %0d sent a beat with no good frame pending", port));
        exp_beat = ref_q[port].pop_front();
        assert (out_beat.beat == exp_beat)
          else report_mismatch("out_beat.beat", 32'(exp_beat), 32'(out_beat.beat));
        released[port] = 1;
      end
      for (int p = 0; p < NUM_PORTS; p++) begin
        if (s_valid[p] && s_ready[p]) begin
          beat = s_beat[p];
          if (dropping[p] || (committed[p] + cur_len[p] >= DEPTH)) begin
            dropping[p] = 1'b1;                  // frame lost for lack of room.
          end else begin
            cur_len[p]++;
            pend_q[p].push_back(beat);
          end
          if (beat.last) begin
            if (dropping[p]) begin
              tally[p].overflow++;
            end else if (beat.bad) begin
              tally[p].bad++;
            end else begin
              tally[p].good++;
              committed[p] += cur_len[p];
              for (int i = 0; i < pend_q[p].size(); i++) begin
                ref_q[p].push_back(pend_q[p][i]);
              end
            end
            dropping[p] = 1'b0;
            cur_len[p]  = 0;
            pend_q[p].delete();
          end
        end
        committed[p] -= released[p];
        tally_d2[p] = tally_d1[p];
        tally_d1[p] = tally[p];
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////////////////////

  task automatic run_traffic();
    int         beats_left [NUM_PORTS];
    int         gap        [NUM_PORTS];
    int         sent       [NUM_PORTS];
    bit         mark_bad   [NUM_PORTS];
    int         stall_left;
    int         cycle;
    bit         busy;
    axis_beat_t beat;
    stall_left = 0;
    cycle      = 0;
    busy       = 1'b1;
    for (int p = 0; p < NUM_PORTS; p++) begin
      beats_left[p] = 0;
      gap[p]        = 0;
      sent[p]       = 0;
      mark_bad[p]   = 1'b0;
    end
    while (busy) begin
      @(posedge clk);
      cycle++;
      busy = 1'b0;
      for (int p = 0; p < NUM_PORTS; p++) begin
        s_valid[p] <= 1'b0;
        if (gap[p] > 0) begin
          gap[p]--;
        end else begin
          if ((beats_left[p] == 0) && (sent[p] < NUM_FRAMES)) begin
            beats_left[p] = 1 + int'($urandom % 20);
            mark_bad[p]   = (($urandom % 5) == 0);  // about one in five.
            sent[p]++;
          end
          if ((beats_left[p] > 0) && (($urandom % 4) != 0)) begin
            beat.data = DATA_W'($urandom);
            beat.last = (beats_left[p] == 1);
            beat.bad  = beat.last && mark_bad[p];
            s_valid[p] <= 1'b1;
            s_beat[p]  <= beat;
            beats_left[p]--;
            if (beat.last) begin
              gap[p] = int'($urandom % 4);
            end
          end
        end
        if ((beats_left[p] > 0) || (sent[p] < NUM_FRAMES)) begin
          busy = 1'b1;
        end
      end
      if ((cycle % STALL_EVERY) == (STALL_EVERY / 2)) begin
        stall_left = STALL_CYCLES;
      end
      if (stall_left > 0) begin
        out_ready <= 1'b0;
        stall_left--;
      end else begin
        out_ready <= (($urandom % 10) >= 3);     // low about 30% of cycles.
      end
    end
  endtask

  task automatic drain_outputs();
    int waited;
    waited = 0;
    @(posedge clk);
    for (int p = 0; p < NUM_PORTS; p++) begin
      s_valid[p] <= 1'b0;
    end
    out_ready <= 1'b1;
    while ((beats_outstanding() != 0) && (waited < DRAIN_CYCLES)) begin
      @(posedge clk);
      waited++;
    end
    repeat (4) @(posedge clk);                   // counters settle.
    assert (beats_outstanding() == 0)
      else report_error("good frames still missing at the output after the drain");
  endtask

  initial begin : watchdog
    #(WATCHDOG_TIME);
    report_error("watchdog expired before the run finished");
  end

  initial begin : main
    void'($urandom(SEED));
    rst       <= 1'b1;
    out_ready <= 1'b0;
    for (int p = 0; p < NUM_PORTS; p++) begin
      s_valid[p] <= 1'b0;
      s_beat[p]  <= '0;
    end
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
    run_traffic();
    drain_outputs();
    $display("*** PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire
